// File: common/riscv_isa_pkg.sv
package riscv_isa_pkg;

    ////////////////////////////////////////
    // base word and field types
    ////////////////////////////////////////

    typedef logic [31:0] instr_t;
    typedef logic [31:0] imm_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // rv32i major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OPC_JALR   = 7'b1100111,
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    // funct3 per alu function, shared by op and op-imm
    localparam funct3_t F3_ADD  = 3'b000;  // add, sub, addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl / sra, split on funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct7_t FUNCT7_ALT = 7'b0100000;  // sub, sra

    ////////////////////////////////////////
    // decoded control
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_NONE     // unknown opcode, nothing to execute
    } alu_op_t;

    typedef logic [2:0] fu_mask_t;  // one bit per execution lane

    localparam fu_mask_t ALU_LANE = 3'b001;
    localparam fu_mask_t BEU_LANE = 3'b010;  // branch / jump unit
    localparam fu_mask_t MEU_LANE = 3'b100;  // load / store unit

    // 46 bits, travels with the op into AR
    typedef struct packed {
        imm_t     imm;
        alu_op_t  alu_op;
        fu_mask_t fu;
        logic     alu_src;    // 1 = immediate as operand 2
        logic     mem_read;
        logic     mem_write;
        logic     rf_write;
        funct3_t  funct3;     // branch cond / access size for the lanes
    } dec_ctrl_t;

endpackage

// File: common/rename_pkg.sv
package rename_pkg;

    import riscv_isa_pkg::*;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int ISSUE_WIDTH  = 2;
    localparam int RETIRE_WIDTH = 2;
    localparam int NUM_SRCS     = 2;
    localparam int ARCH_REGS    = 32;
    localparam int ROB_ENTRIES  = 32;
    localparam int TAG_W        = 5;   // wide enough for a reg number or a rob id

    // source slot index
    localparam int SRC_RS1 = 0;
    localparam int SRC_RS2 = 1;

    typedef logic [$clog2(ARCH_REGS)-1:0]   arch_reg_t;
    typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_id_t;
    typedef logic [TAG_W-1:0]               tag_t;

    ////////////////////////////////////////
    // alias table entry
    ////////////////////////////////////////

    typedef enum logic {
        SRC_ROB  = 1'b0,   // value still in flight, tag is a rob id
        SRC_ARCH = 1'b1    // value in the arch regfile, tag is the reg
    } src_kind_t;

    typedef struct packed {
        src_kind_t kind;
        tag_t      tag;
    } rat_entry_t;

    ////////////////////////////////////////
    // stage buses
    ////////////////////////////////////////

    typedef struct packed {
        logic    valid;
        instr_t  instr;
        rob_id_t rob_id;   // rob slot allocated for this instr
    } issue_slot_t;

    typedef struct packed {
        logic      valid;
        logic      rf_write;  // stores and branches retire without a write
        arch_reg_t rd;
        rob_id_t   rob_id;
    } retire_slot_t;

    // decoder output, one per slot
    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        dec_ctrl_t ctrl;
    } dec_slot_t;

    // AR stage result handed to dispatch
    typedef struct packed {
        logic                       valid;
        opcode_t                    opcode;
        arch_reg_t                  rd;
        rob_id_t                    rob_id;
        rat_entry_t [NUM_SRCS-1:0]  src;
        dec_ctrl_t                  ctrl;
    } renamed_op_t;

endpackage

// File: decode/instr_decoder.sv
module instr_decoder
    import riscv_isa_pkg::*;
    import rename_pkg::*;
(
    input  instr_t    instr,
    output dec_slot_t dec
);

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    alu_op_t   f3_alu_op;   // alu op implied by funct3 alone
    dec_ctrl_t ctrl;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////////////////////////
    // alu function from funct3 / funct7
    ////////////////////////////////////////

    always_comb begin
        case (funct3)
            F3_ADD:  f3_alu_op = ALU_ADD;
            F3_SLL:  f3_alu_op = ALU_SLL;
            F3_SLT:  f3_alu_op = ALU_SLT;
            F3_SLTU: f3_alu_op = ALU_SLT;   // unsigned flavour via funct3 in the lane
            F3_XOR:  f3_alu_op = ALU_XOR;
            F3_SR:   f3_alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:   f3_alu_op = ALU_OR;
            F3_AND:  f3_alu_op = ALU_AND;
            default: f3_alu_op = ALU_NONE;
        endcase
    end

    ////////////////////////////////////////
    // immediate and class control
    ////////////////////////////////////////

    always_comb begin
        // default is the unknown-opcode case
        ctrl           = '0;
        ctrl.alu_op    = ALU_NONE;
        ctrl.funct3    = funct3;

        case (opcode)
            OPC_JALR: begin
                ctrl.imm      = {{20{instr[31]}}, instr[31:20]};   // i-type
                ctrl.alu_op   = ALU_ADD;        // target = rs1 + imm
                ctrl.fu       = BEU_LANE;
                ctrl.alu_src  = 1'b1;
                ctrl.rf_write = 1'b1;           // link reg
            end
            OPC_LOAD: begin
                ctrl.imm      = {{20{instr[31]}}, instr[31:20]};
                ctrl.alu_op   = ALU_ADD;        // address gen
                ctrl.fu       = MEU_LANE;
                ctrl.alu_src  = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.rf_write = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.imm      = {{20{instr[31]}}, instr[31:20]};
                ctrl.alu_op   = f3_alu_op;      // no subi
                ctrl.fu       = ALU_LANE;
                ctrl.alu_src  = 1'b1;
                ctrl.rf_write = 1'b1;
            end
            OPC_LUI: begin
                ctrl.imm      = {instr[31:12], 12'b0};             // u-type
                ctrl.alu_op   = ALU_ADD;        // x0 + imm
                ctrl.fu       = ALU_LANE;
                ctrl.alu_src  = 1'b1;
                ctrl.rf_write = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.imm      = {instr[31:12], 12'b0};
                ctrl.alu_op   = ALU_ADD;        // pc + imm
                ctrl.fu       = ALU_LANE;
                ctrl.alu_src  = 1'b1;
                ctrl.rf_write = 1'b1;
            end
            OPC_JAL: begin
                // j-type, bit 0 always zero
                ctrl.imm      = {{11{instr[31]}}, instr[31], instr[19:12],
                                 instr[20], instr[30:21], 1'b0};
                ctrl.alu_op   = ALU_ADD;
                ctrl.fu       = BEU_LANE;
                ctrl.alu_src  = 1'b1;
                ctrl.rf_write = 1'b1;           // pc+4 into rd
            end
            OPC_STORE: begin
                ctrl.imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // s-type
                ctrl.alu_op    = ALU_ADD;
                ctrl.fu        = MEU_LANE;
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.imm      = {{19{instr[31]}}, instr[31], instr[7],
                                 instr[30:25], instr[11:8], 1'b0};  // b-type
                ctrl.alu_op   = ALU_SUB;        // compare, cond from funct3
                ctrl.fu       = BEU_LANE;
            end
            OPC_OP: begin
                ctrl.alu_op   = (funct3 == F3_ADD && funct7 == FUNCT7_ALT) ? ALU_SUB
                                                                           : f3_alu_op;
                ctrl.fu       = ALU_LANE;
                ctrl.rf_write = 1'b1;           // both operands from regs
            end
            default: ;
        endcase
    end

    assign dec = '{rd: instr[11:7], rs1: instr[19:15], rs2: instr[24:20], ctrl: ctrl};

endmodule

// File: rename/rat_table.sv
module rat_table
    import rename_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      rst,
    input  issue_slot_t  [ISSUE_WIDTH-1:0]            issue,
    input  logic                                      rob_full,
    input  dec_slot_t    [ISSUE_WIDTH-1:0]            dec,
    input  retire_slot_t [RETIRE_WIDTH-1:0]           retire,
    output rat_entry_t   [ISSUE_WIDTH-1:0][NUM_SRCS-1:0] src_entries
);

    rat_entry_t [ARCH_REGS-1:0] rat_q;    // front-end alias table

    logic [ISSUE_WIDTH-1:0]  iss_we;      // rename write per issue slot
    logic [RETIRE_WIDTH-1:0] ret_we;      // release write per retire slot

    ////////////////////////////////////////
    // read ports, pre-write state
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            src_entries[i][SRC_RS1] = rat_q[dec[i].rs1];
            src_entries[i][SRC_RS2] = rat_q[dec[i].rs2];
        end
    end

    ////////////////////////////////////////
    // write port arbitration
    ////////////////////////////////////////

    // issue side: x0 is never renamed, a stalled group writes nothing
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            iss_we[i] = issue[i].valid & ~rob_full
                      & dec[i].ctrl.rf_write & (dec[i].rd != '0);
        end
    end

    // retire side: only release if this rob id still owns the entry
    always_comb begin
        for (int r = 0; r < RETIRE_WIDTH; r++) begin
            ret_we[r] = retire[r].valid & retire[r].rf_write
                      & (rat_q[retire[r].rd].kind == SRC_ROB)
                      & (rat_q[retire[r].rd].tag  == tag_t'(retire[r].rob_id));

            // a new rename of the same reg this cycle beats the release
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (iss_we[i] && (dec[i].rd == retire[r].rd)) begin
                    ret_we[r] = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // table update
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < ARCH_REGS; k++) begin
                rat_q[k].kind <= SRC_ARCH;      // identity map
                rat_q[k].tag  <= tag_t'(k);
            end
        end else begin
            // higher retire port lands last on a shared rd
            for (int r = 0; r < RETIRE_WIDTH; r++) begin
                if (ret_we[r]) begin
                    rat_q[retire[r].rd] <= '{kind: SRC_ARCH, tag: tag_t'(retire[r].rd)};
                end
            end
            // younger slot lands last, so slot 1 wins a shared rd
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (iss_we[i]) begin
                    rat_q[dec[i].rd] <= '{kind: SRC_ROB, tag: tag_t'(issue[i].rob_id)};
                end
            end
        end
    end

endmodule

// File: rename/rename_fixup.sv
module rename_fixup
    import riscv_isa_pkg::*;
    import rename_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      rst,
    input  issue_slot_t  [ISSUE_WIDTH-1:0]            issue,
    input  logic                                      rob_full,
    input  dec_slot_t    [ISSUE_WIDTH-1:0]            dec,
    input  rat_entry_t   [ISSUE_WIDTH-1:0][NUM_SRCS-1:0] src_entries,
    input  retire_slot_t [RETIRE_WIDTH-1:0]           retire,
    output renamed_op_t  [ISSUE_WIDTH-1:0]            renamed
);

    // true when a retiring producer matches a rob-tagged source
    function automatic logic retire_match(retire_slot_t ret, rat_entry_t ent);
        return ret.valid & ret.rf_write & (ent.kind == SRC_ROB)
             & (ent.tag == tag_t'(ret.rob_id));
    endfunction

    ////////////////////////////////////////
    // ID/AR stage register
    ////////////////////////////////////////

    renamed_op_t  [ISSUE_WIDTH-1:0]                op_q;       // src holds raw table reads
    arch_reg_t    [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]  src_reg_q;  // original rs1 / rs2
    retire_slot_t [RETIRE_WIDTH-1:0]               retire_q;   // retire bus seen in ID

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q      <= '0;
            src_reg_q <= '0;
            retire_q  <= '0;
        end else begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                op_q[i].valid  <= issue[i].valid & ~rob_full;   // stalled slot dropped
                op_q[i].opcode <= opcode_t'(issue[i].instr[6:0]);
                op_q[i].rd     <= dec[i].rd;
                op_q[i].rob_id <= issue[i].rob_id;
                op_q[i].src    <= src_entries[i];
                op_q[i].ctrl   <= dec[i].ctrl;
                src_reg_q[i][SRC_RS1] <= dec[i].rs1;
                src_reg_q[i][SRC_RS2] <= dec[i].rs2;
            end
            retire_q <= retire;   // release may have lost to the table read
        end
    end

    ////////////////////////////////////////
    // dependency matches
    ////////////////////////////////////////

    logic    [ISSUE_WIDTH-1:0][NUM_SRCS-1:0] grp_hit;      // older slot in group writes src
    rob_id_t [ISSUE_WIDTH-1:0][NUM_SRCS-1:0] grp_rob;      // rob id of nearest such writer
    logic    [ISSUE_WIDTH-1:0][NUM_SRCS-1:0] ret_now_hit;  // producer retiring in AR
    logic    [ISSUE_WIDTH-1:0][NUM_SRCS-1:0] ret_old_hit;  // producer retired in ID

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            for (int s = 0; s < NUM_SRCS; s++) begin
                grp_hit[i][s]     = 1'b0;
                grp_rob[i][s]     = '0;
                ret_now_hit[i][s] = 1'b0;
                ret_old_hit[i][s] = 1'b0;

                // table read missed writes from older slots, nearest one wins
                for (int j = 0; j < i; j++) begin
                    if (op_q[j].valid && op_q[j].ctrl.rf_write && (op_q[j].rd != '0)
                        && (op_q[j].rd == src_reg_q[i][s])) begin
                        grp_hit[i][s] = op_q[i].valid;
                        grp_rob[i][s] = op_q[j].rob_id;
                    end
                end

                for (int r = 0; r < RETIRE_WIDTH; r++) begin
                    ret_now_hit[i][s] |= op_q[i].valid & retire_match(retire[r], op_q[i].src[s]);
                    ret_old_hit[i][s] |= op_q[i].valid
                                       & retire_match(retire_q[r], op_q[i].src[s]);
                end
            end
        end
    end

    ////////////////////////////////////////
    // source select
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            renamed[i] = op_q[i];
            for (int s = 0; s < NUM_SRCS; s++) begin
                if (grp_hit[i][s]) begin
                    renamed[i].src[s] = '{kind: SRC_ROB, tag: tag_t'(grp_rob[i][s])};
                end else if (ret_now_hit[i][s] || ret_old_hit[i][s]) begin
                    // value now in regfile, both retire cases point at rs
                    renamed[i].src[s] = '{kind: SRC_ARCH, tag: tag_t'(src_reg_q[i][s])};
                end
            end
        end
    end

endmodule

// File: src/frontend_rename.sv
module frontend_rename
    import rename_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  issue_slot_t  [ISSUE_WIDTH-1:0]  issue,
    input  logic                            rob_full,   // drops the whole group
    input  retire_slot_t [RETIRE_WIDTH-1:0] retire,
    output renamed_op_t  [ISSUE_WIDTH-1:0]  renamed     // one cycle after issue
);

    dec_slot_t  [ISSUE_WIDTH-1:0]                dec;          // ID stage decode
    rat_entry_t [ISSUE_WIDTH-1:0][NUM_SRCS-1:0]  src_entries;  // raw table reads

    ////////////////////////////////////////
    // decode, one per slot
    ////////////////////////////////////////

    for (genvar g = 0; g < ISSUE_WIDTH; g++) begin : g_dec
        instr_decoder i_dec (
            .instr (issue[g].instr),
            .dec   (dec[g])
        );
    end

    rat_table i_rat (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .rob_full    (rob_full),
        .dec         (dec),
        .retire      (retire),
        .src_entries (src_entries)
    );

    // AR stage, corrects what the table could not see
    rename_fixup i_fixup (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .rob_full    (rob_full),
        .dec         (dec),
        .src_entries (src_entries),
        .retire      (retire),
        .renamed     (renamed)
    );

endmodule

// File: dv/frontend_rename_tests.svh
////////////////////////////////////////
// expected decode from the rv32i rules
////////////////////////////////////////

function automatic alu_op_t alu_from_funct3(instr_t w, logic is_op);
    case (w[14:12])
        3'd0:    return (is_op && w[31:25] == 7'b0100000) ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLT;
        3'd4:    return ALU_XOR;
        3'd5:    return (w[31:25] == 7'b0100000) ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic dec_ctrl_t exp_ctrl(instr_t w);
    dec_ctrl_t c;
    c        = '0;
    c.alu_op = ALU_NONE;
    c.funct3 = w[14:12];
    case (w[6:0])
        7'b1100111: c = '{imm: {{20{w[31]}}, w[31:20]}, alu_op: ALU_ADD, fu: BEU_LANE,
                          alu_src: 1, mem_read: 0, mem_write: 0, rf_write: 1, funct3: w[14:12]};
        7'b0000011: c = '{imm: {{20{w[31]}}, w[31:20]}, alu_op: ALU_ADD, fu: MEU_LANE,
                          alu_src: 1, mem_read: 1, mem_write: 0, rf_write: 1, funct3: w[14:12]};
        7'b0010011: c = '{imm: {{20{w[31]}}, w[31:20]}, alu_op: alu_from_funct3(w, 0),
                          fu: ALU_LANE, alu_src: 1, mem_read: 0, mem_write: 0, rf_write: 1,
                          funct3: w[14:12]};
        7'b0110111,
        7'b0010111: c = '{imm: {w[31:12], 12'b0}, alu_op: ALU_ADD, fu: ALU_LANE,
                          alu_src: 1, mem_read: 0, mem_write: 0, rf_write: 1, funct3: w[14:12]};
        7'b1101111: c = '{imm: {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0},
                          alu_op: ALU_ADD, fu: BEU_LANE, alu_src: 1, mem_read: 0,
                          mem_write: 0, rf_write: 1, funct3: w[14:12]};
        7'b0100011: c = '{imm: {{20{w[31]}}, w[31:25], w[11:7]}, alu_op: ALU_ADD, fu: MEU_LANE,
                          alu_src: 1, mem_read: 0, mem_write: 1, rf_write: 0, funct3: w[14:12]};
        7'b1100011: c = '{imm: {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0},
                          alu_op: ALU_SUB, fu: BEU_LANE, alu_src: 0, mem_read: 0,
                          mem_write: 0, rf_write: 0, funct3: w[14:12]};
        7'b0110011: c = '{imm: '0, alu_op: alu_from_funct3(w, 1), fu: ALU_LANE, alu_src: 0,
                          mem_read: 0, mem_write: 0, rf_write: 1, funct3: w[14:12]};
        default: ;
    endcase
    return c;
endfunction

// instr renames its rd, x0 never does
function automatic logic writes_rd(instr_t w);
    dec_ctrl_t c;
    c = exp_ctrl(w);
    return c.rf_write && w[11:7] != 0;
endfunction

////////////////////////////////////////
// reference rename model
////////////////////////////////////////

function automatic logic owner_retired(retire_slot_t r, rat_entry_t e);
    return r.valid && r.rf_write && e.kind == SRC_ROB && e.tag == tag_t'(r.rob_id);
endfunction

function automatic void model_reset();
    for (int k = 0; k < ARCH_REGS; k++) ref_rat[k] = '{kind: SRC_ARCH, tag: tag_t'(k)};
    for (int i = 0; i < ISSUE_WIDTH; i++) pend_vld[i] = 1'b0;
    for (int r = 0; r < RETIRE_WIDTH; r++) pend_ret[r] = '0;
endfunction

// compares the group in AR against the model, current retire bus applied
task automatic check_group();
    renamed_op_t e;
    arch_reg_t   reg_no;
    logic        hit;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
        check_eq(128'(renamed[i].valid), 128'(pend_vld[i]), $sformatf("slot %0d valid", i));
        if (pend_vld[i]) begin
            e.valid  = 1'b1;
            e.opcode = opcode_t'(pend_iss[i].instr[6:0]);
            e.rd     = pend_iss[i].instr[11:7];
            e.rob_id = pend_iss[i].rob_id;
            e.ctrl   = exp_ctrl(pend_iss[i].instr);
            for (int s = 0; s < NUM_SRCS; s++) begin
                reg_no   = (s == 0) ? pend_iss[i].instr[19:15] : pend_iss[i].instr[24:20];
                e.src[s] = pend_raw[i][s];
                hit      = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (pend_vld[j] && writes_rd(pend_iss[j].instr)
                        && pend_iss[j].instr[11:7] == reg_no) begin
                        e.src[s] = '{kind: SRC_ROB, tag: tag_t'(pend_iss[j].rob_id)};
                        hit      = 1'b1;
                    end
                end
                for (int r = 0; r < RETIRE_WIDTH; r++) begin
                    if (!hit && (owner_retired(retire[r], pend_raw[i][s])
                                 || owner_retired(pend_ret[r], pend_raw[i][s]))) begin
                        e.src[s] = '{kind: SRC_ARCH, tag: tag_t'(reg_no)};
                    end
                end
            end
            check_eq(128'(renamed[i]), 128'(e), $sformatf("slot %0d renamed op", i));
        end
    end
endtask

// one cycle: drive on the falling edge, check the AR group, advance the model
task automatic step(input issue_slot_t s0, input issue_slot_t s1, input logic full,
                    input retire_slot_t r0, input retire_slot_t r1);
    logic [ISSUE_WIDTH-1:0]  iw;
    logic [RETIRE_WIDTH-1:0] rw;
    @(negedge clk);
    issue    = {s1, s0};
    rob_full = full;
    retire   = {r1, r0};
    #1;
    check_group();
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
        pend_iss[i]    = issue[i];
        pend_vld[i]    = issue[i].valid && !full;
        pend_raw[i][0] = ref_rat[issue[i].instr[19:15]];
        pend_raw[i][1] = ref_rat[issue[i].instr[24:20]];
        iw[i] = pend_vld[i] && writes_rd(issue[i].instr);
    end
    for (int r = 0; r < RETIRE_WIDTH; r++) begin
        rw[r] = owner_retired(retire[r], ref_rat[retire[r].rd]);
        for (int i = 0; i < ISSUE_WIDTH; i++)
            if (iw[i] && issue[i].instr[11:7] == retire[r].rd) rw[r] = 1'b0;
    end
    for (int r = 0; r < RETIRE_WIDTH; r++)
        if (rw[r]) ref_rat[retire[r].rd] = '{kind: SRC_ARCH, tag: tag_t'(retire[r].rd)};
    for (int i = 0; i < ISSUE_WIDTH; i++)
        if (iw[i]) ref_rat[issue[i].instr[11:7]] = '{kind: SRC_ROB, tag: tag_t'(issue[i].rob_id)};
    for (int r = 0; r < RETIRE_WIDTH; r++) pend_ret[r] = retire[r];
endtask

////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////

function automatic arch_reg_t rand_reg();
    return arch_reg_t'(rand_bits(5));
endfunction

function automatic instr_t make_instr(logic [6:0] opc, arch_reg_t rd, arch_reg_t rs1,
                                      arch_reg_t rs2);
    instr_t w;
    w        = rand_bits(32);   // random funct and immediate bits
    w[6:0]   = opc;
    w[11:7]  = rd;
    w[19:15] = rs1;
    w[24:20] = rs2;
    return w;
endfunction

function automatic issue_slot_t slot(instr_t w, rob_id_t rob);
    return '{valid: 1'b1, instr: w, rob_id: rob};
endfunction

function automatic issue_slot_t idle_slot();
    return '{valid: 1'b0, instr: '0, rob_id: '0};
endfunction

function automatic retire_slot_t ret_slot(arch_reg_t rd, rob_id_t rob);
    return '{valid: 1'b1, rf_write: 1'b1, rd: rd, rob_id: rob};
endfunction

function automatic retire_slot_t no_retire();
    return '0;
endfunction

// reader that writes nothing, a store
function automatic issue_slot_t reader(arch_reg_t a, arch_reg_t b, rob_id_t rob);
    return slot(make_instr(7'b0100011, rand_reg(), a, b), rob);
endfunction

// writer from the op class
function automatic issue_slot_t writer(arch_reg_t rd, rob_id_t rob);
    return slot(make_instr(7'b0110011, rd, rand_reg(), rand_reg()), rob);
endfunction

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic test_reset();
    step(reader(rand_reg(), rand_reg(), 1), reader(rand_reg(), rand_reg(), 2),
         1'b0, no_retire(), no_retire());   // also sees valid low after reset
    step(idle_slot(), idle_slot(), 1'b0, no_retire(), no_retire());
endtask

task automatic test_decode();
    logic [6:0] opcs [10];
    opcs = '{7'b1100111, 7'b0000011, 7'b0010011, 7'b0110111, 7'b0010111,
             7'b1101111, 7'b0100011, 7'b1100011, 7'b0110011, 7'b1111111};
    for (int rep = 0; rep < 3; rep++) begin
        for (int k = 0; k < 10; k++) begin
            step(slot(make_instr(opcs[k], rand_reg(), rand_reg(), rand_reg()),
                      rob_id_t'(rand_bits(5))), idle_slot(), 1'b0, no_retire(), no_retire());
        end
    end
endtask

task automatic test_rename();
    arch_reg_t a;
    arch_reg_t b;
    a = arch_reg_t'(1 + rand_bits(4) % 15);
    b = arch_reg_t'(16 + rand_bits(4) % 15);
    step(writer(a, 3), writer(b, 4), 1'b0, no_retire(), no_retire());
    step(reader(a, b, 5), reader(b, a, 6), 1'b0, no_retire(), no_retire());
    step(writer(a, 7), writer(a, 8), 1'b0, no_retire(), no_retire());   // slot 1 wins
    step(reader(a, b, 9), idle_slot(), 1'b0, no_retire(), no_retire());
    step(idle_slot(), idle_slot(), 1'b0, no_retire(), no_retire());
endtask

task automatic test_same_group();
    arch_reg_t a;
    a = arch_reg_t'(1 + rand_bits(5) % 31);
    step(writer(a, 9), reader(a, a, 10), 1'b0, no_retire(), no_retire());
    step(writer(a, 11), writer(a, 12), 1'b1, no_retire(), no_retire());  // stalled
    step(reader(a, 0, 13), idle_slot(), 1'b0, no_retire(), no_retire());
    step(idle_slot(), idle_slot(), 1'b0, no_retire(), no_retire());
endtask

task automatic test_retire();
    arch_reg_t a;
    a = arch_reg_t'(1 + rand_bits(5) % 31);
    step(writer(a, 12), idle_slot(), 1'b0, no_retire(), no_retire());
    // producer retires in the reader's ID cycle
    step(reader(a, a, 13), idle_slot(), 1'b0, ret_slot(a, 12), no_retire());
    step(writer(a, 14), idle_slot(), 1'b0, no_retire(), no_retire());
    step(reader(a, 0, 15), idle_slot(), 1'b0, no_retire(), no_retire());
    // producer retires in the reader's AR cycle
    step(idle_slot(), idle_slot(), 1'b0, no_retire(), ret_slot(a, 14));
    step(writer(a, 16), idle_slot(), 1'b0, no_retire(), no_retire());
    step(writer(a, 17), idle_slot(), 1'b0, no_retire(), no_retire());
    // stale retire, newer mapping stays
    step(idle_slot(), idle_slot(), 1'b0, ret_slot(a, 16), no_retire());
    step(reader(a, a, 18), idle_slot(), 1'b0, no_retire(), no_retire());
    step(idle_slot(), idle_slot(), 1'b0, no_retire(), no_retire());
endtask

// File: dv/frontend_rename_tb.sv
module frontend_rename_tb
    import riscv_isa_pkg::*;
    import rename_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    // reset and release, then the steps of each test in order
    localparam int TEST_CYCLES   = 9 + 2 + 30 + 5 + 4 + 10 + 1;
    localparam int MARGIN_CYCLES = 60;

    logic                            clk;
    logic                            rst;
    issue_slot_t  [ISSUE_WIDTH-1:0]  issue;
    logic                            rob_full;
    retire_slot_t [RETIRE_WIDTH-1:0] retire;
    renamed_op_t  [ISSUE_WIDTH-1:0]  renamed;

    logic [31:0] lfsr_q;

    // reference model state
    rat_entry_t   ref_rat  [ARCH_REGS];
    issue_slot_t  pend_iss [ISSUE_WIDTH];     // group now in AR
    logic         pend_vld [ISSUE_WIDTH];
    rat_entry_t   pend_raw [ISSUE_WIDTH][NUM_SRCS];  // table reads seen in ID
    retire_slot_t pend_ret [RETIRE_WIDTH];    // retire bus of the ID cycle

    frontend_rename i_dut (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .rob_full (rob_full),
        .retire   (retire),
        .renamed  (renamed)
    );

    always #2 clk = ~clk;   // 4 ns period

    ////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////

    // galois lfsr, x^32+x^22+x^2+x+1
    function automatic logic next_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v = {v[30:0], next_bit()};
        return v;
    endfunction

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("Regression failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    // watchdog
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * 4);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    `include "frontend_rename_tests.svh"

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        issue    = '0;
        rob_full = 1'b0;
        retire   = '0;
        lfsr_q   = 32'h5da6_126e;
        model_reset();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_decode();
        test_rename();
        test_same_group();
        test_retire();
        step(idle_slot(), idle_slot(), 1'b0, no_retire(), no_retire());

        $display("Regression passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+dv
common/riscv_isa_pkg.sv
common/rename_pkg.sv
decode/instr_decoder.sv
rename/rat_table.sv
rename/rename_fixup.sv
src/frontend_rename.sv
dv/frontend_rename_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sources.f --top-module frontend_rename_tb -o sim
	-./obj_dir/sim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
